/* sim/i2c_cases.txt */
# W dev word_hi word_lo fill(f=listed r=random) count bytes end(p=stop h=half byte s=restart)
# X dev (no acknowledge)    R addr source(f=listed r=reference model) expected
W a6 01 20 f 4 11223344 p
R 120 f 11
R 121 f 22
R 122 f 33
R 123 f 44
W a2 01 21 f 2 eeff p
R 121 f 22
R 122 f 33
X a7
R 120 f 11
W a6 0f fe f 3 a1b2c3 p
R 7fe f a1
R 7ff f b2
R 000 f c3
W a6 02 00 f 4 01020304 p
W a6 02 00 f 2 5566 h
R 200 f 55
R 201 f 66
R 202 f 03
W a6 03 00 r 3 0 s
W a6 03 80 f 2 c0de p
R 300 r 0
R 301 r 0
R 302 r 0
R 380 f c0
R 381 f de

/* project.f */
src/i2c_pkg.sv
src/i2c_line_sync.sv
src/i2c_deserializer.sv
src/burst_store.sv
src/i2c_slave_top.sv
sim/i2c_slave_assert.sv
sim/tb_i2c_slave.sv

/* Makefile */
VERILATOR ?= verilator
TOP := tb_i2c_slave
FILELIST := project.f
VFLAGS := --binary --assert --timing
LINT_FLAGS := --lint-only --assert --timing
SIM_ARGS := +verilator+error+limit+100
OBJ_DIR := obj_dir
PASS_TEXT := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_i2c_slave.sv */
`timescale 1ns/1ps

module tb_i2c_slave;

	logic Clock;
	logic Reset;
	logic scl;
	logic sda_master;
	wire sda_in;
	logic [2:0] dev_select;
	logic [10:0] rd_addr;
	logic sda_drive_low;
	logic bus_busy;
	logic [7:0] rd_data;
	logic write_strobe;
	logic [10:0] write_addr;
	logic [7:0] write_data;

	// case lines and their parsed fields
	string case_lines[$];
	logic [7:0] kind;
	logic [7:0] fill;
	logic [7:0] end_mode;
	logic [31:0] dev;
	logic [31:0] hi;
	logic [31:0] lo;
	logic [31:0] addr;
	logic [31:0] exp_byte;
	logic [63:0] data;
	int count;

	// reference model of the store
	logic [7:0] ref_mem [2048];
	logic [10:0] exp_addr_q[$];
	logic [7:0] exp_data_q[$];
	logic [10:0] mon_addr;
	logic [7:0] mon_data;
	logic [31:0] lcg_state = 32'h97af_e9ff;
	int cycle_count = 0;
	int cycle_limit = 0;

	// open drain bus, target can only pull low
	assign sda_in = sda_master & ~sda_drive_low;

	i2c_slave_top dut0 (
		.Clock(Clock),
		.Reset(Reset),
		.scl(scl),
		.sda_in(sda_in),
		.dev_select(dev_select),
		.rd_addr(rd_addr),
		.sda_drive_low(sda_drive_low),
		.bus_busy(bus_busy),
		.rd_data(rd_data),
		.write_strobe(write_strobe),
		.write_addr(write_addr),
		.write_data(write_data)
	);

	initial
	begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
			abort_run($sformatf("%s differs from its expected value", name));
		end
	endtask

	function automatic logic [7:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];
	endfunction

	task automatic wait_clocks(input int n);
		repeat (n) @(posedge Clock);
		#1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus master, 8 clocks per scl half period
	////////////////////////////////////////////////////////////////////////////

	task automatic send_bit(input logic b);
		wait_clocks(4);
		sda_master = b;
		wait_clocks(4);
		scl = 1'b1;
		wait_clocks(8);
		scl = 1'b0;
	endtask

	task automatic send_byte(input logic [7:0] b, input logic ack_exp);
		logic ack;
		for (int i = 7; i >= 0; i--)
			send_bit(b[i]);
		wait_clocks(4);
		sda_master = 1'b1;
		wait_clocks(4);
		scl = 1'b1;
		wait_clocks(4);
		// mid high phase of the 9th clock
		ack = !sda_in;
		wait_clocks(4);
		scl = 1'b0;
		check_value("ack", 32'(ack_exp), 32'(ack));
	endtask

	// also serves as repeated start when scl is low
	task automatic bus_start();
		wait_clocks(4);
		sda_master = 1'b1;
		wait_clocks(4);
		scl = 1'b1;
		wait_clocks(4);
		sda_master = 1'b0;
		wait_clocks(4);
		scl = 1'b0;
	endtask

	task automatic bus_stop();
		wait_clocks(4);
		sda_master = 1'b0;
		wait_clocks(4);
		scl = 1'b1;
		wait_clocks(4);
		sda_master = 1'b1;
		wait_clocks(8);
		check_value("bus_busy", 32'd0, 32'(bus_busy));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// case file handling
	////////////////////////////////////////////////////////////////////////////

	task automatic load_cases();
		int fd;
		int code;
		int units;
		string line;
		fd = $fopen("sim/i2c_cases.txt", "r");
		if (fd == 0)
			abort_run("cannot open the case file sim/i2c_cases.txt");
		units = 0;
		while (!$feof(fd))
		begin
			line = "";
			code = $fgets(line, fd);
			if (code > 0 && (line[0] == "W" || line[0] == "X" || line[0] == "R"))
			begin
				case_lines.push_back(line);
				units = units + 1;
				if (line[0] == "W")
				begin
					code = $sscanf(line, "%c %h %h %h %c %d", kind, dev, hi, lo, fill, count);
					units = units + 3 + count;
				end
				else if (line[0] == "X")
				begin
					// rejected device byte plus three ignored bytes
					units = units + 3;
				end
			end
		end
		$fclose(fd);
		// 9 bits of 16 clocks per byte, doubled
		cycle_limit = units * 9 * 16 * 2;
	endtask

	task automatic run_write(input string line);
		int code;
		logic matched;
		logic [10:0] ptr;
		logic [7:0] b;
		code = $sscanf(line, "%c %h %h %h %c %d %h %c", kind, dev, hi, lo, fill, count, data,
			end_mode);
		if (code != 8)
			abort_run("malformed write line in the case file");
		matched = (dev[7:1] == {4'b1010, dev_select}) && !dev[0];
		// only the low 11 bits of the word address count
		ptr = {hi[2:0], lo[7:0]};
		bus_start();
		send_byte(dev[7:0], matched);
		check_value("bus_busy", 32'd1, 32'(bus_busy));
		send_byte(hi[7:0], matched);
		send_byte(lo[7:0], matched);
		for (int i = 0; i < count; i++)
		begin
			if (fill == "r")
				b = lcg_next();
			else
				b = data[8*(count-1-i) +: 8];
			if (matched)
			begin
				exp_addr_q.push_back(ptr);
				exp_data_q.push_back(b);
				ref_mem[ptr] = b;
				// wraps from 2047 to 0
				ptr = ptr + 11'd1;
			end
			send_byte(b, matched);
		end
		if (end_mode == "h")
		begin
			// half a byte, then the stop drops it
			b = lcg_next();
			for (int i = 7; i >= 4; i--)
				send_bit(b[i]);
		end
		if (end_mode != "s")
			bus_stop();
	endtask

	task automatic run_reject(input string line);
		int code;
		code = $sscanf(line, "%c %h", kind, dev);
		bus_start();
		send_byte(dev[7:0], 1'b0);
		// target stays off the bus and stores nothing until the stop
		for (int i = 0; i < 3; i++)
			send_byte(lcg_next(), 1'b0);
		bus_stop();
	endtask

	task automatic run_read(input string line);
		int code;
		logic [7:0] expected;
		code = $sscanf(line, "%c %h %c %h", kind, addr, fill, exp_byte);
		rd_addr = addr[10:0];
		wait_clocks(1);
		if (fill == "r")
			expected = ref_mem[addr[10:0]];
		else
			expected = exp_byte[7:0];
		check_value("rd_data", 32'(expected), 32'(rd_data));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// monitors
	////////////////////////////////////////////////////////////////////////////

	always @(posedge Clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
			abort_run($sformatf("timeout after %0d cycles, the bus transfers never finished",
				cycle_count));
	end

	always @(negedge Clock)
	begin
		if (Reset && write_strobe)
		begin
			if (exp_addr_q.size() == 0)
				abort_run("write_strobe pulsed although no write was expected");
			else
			begin
				mon_addr = exp_addr_q.pop_front();
				mon_data = exp_data_q.pop_front();
				check_value("write_addr", 32'(mon_addr), 32'(write_addr));
				check_value("write_data", 32'(mon_data), 32'(write_data));
			end
		end
		check_value("assertion_failures", 32'd0, 32'(dut0.deser0.assert0.busy_fails
			+ dut0.deser0.assert0.idle_fails + dut0.deser0.assert0.pulse_fails));
	end

	initial
	begin
		Reset = 1'b0;
		scl = 1'b1;
		sda_master = 1'b1;
		dev_select = 3'b011;
		rd_addr = '0;
		load_cases();
		wait_clocks(5);
		Reset = 1'b1;
		wait_clocks(4);
		foreach (case_lines[n])
		begin
			kind = case_lines[n][0];
			if (kind == "W")
				run_write(case_lines[n]);
			else if (kind == "X")
				run_reject(case_lines[n]);
			else
				run_read(case_lines[n]);
		end
		wait_clocks(4);
		if (exp_addr_q.size() != 0)
			abort_run("some expected store writes never showed on write_strobe");
		else
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

/* sim/i2c_slave_assert.sv */
`timescale 1ns/1ps

module i2c_slave_assert (
	input  logic Clock,
	input  logic Reset,
	input  i2c_pkg::bus_phase_t phase,
	input  logic sda_drive_low,
	input  logic bus_busy,
	input  logic byte_write
);

	import i2c_pkg::*;

	int busy_fails = 0;
	int idle_fails = 0;
	int pulse_fails = 0;

	// write_strobe is byte_write one cycle later
	write_in_transfer: assert property (@(posedge Clock) disable iff (!Reset)
		byte_write |=> bus_busy)
	else
	begin
		busy_fails++;
		$error("store write outside a bus transfer");
	end

	quiet_when_idle: assert property (@(posedge Clock) disable iff (!Reset)
		(phase == phase_idle) |-> !sda_drive_low)
	else
	begin
		idle_fails++;
		$error("sda pulled low while idle");
	end

	single_write_pulse: assert property (@(posedge Clock) disable iff (!Reset)
		byte_write |=> !byte_write)
	else
	begin
		pulse_fails++;
		$error("byte_write longer than one cycle");
	end

endmodule

bind i2c_deserializer i2c_slave_assert assert0 (
	.Clock(Clock),
	.Reset(Reset),
	.phase(phase),
	.sda_drive_low(sda_drive_low),
	.bus_busy(bus_busy),
	.byte_write(byte_write)
);

/* src/i2c_slave_top.sv */
`timescale 1ns/1ps

module i2c_slave_top (
	input  logic Clock,
	input  logic Reset,
	input  logic scl,
	input  logic sda_in,
	input  logic [i2c_pkg::DEV_SEL_WIDTH-1:0] dev_select,
	input  logic [i2c_pkg::WORD_ADDR_WIDTH-1:0] rd_addr,
	output logic sda_drive_low,
	output logic bus_busy,
	output logic [i2c_pkg::BYTE_WIDTH-1:0] rd_data,
	output logic write_strobe,
	output logic [i2c_pkg::WORD_ADDR_WIDTH-1:0] write_addr,
	output logic [i2c_pkg::BYTE_WIDTH-1:0] write_data
);

	import i2c_pkg::*;

	// synchronized bus
	logic sda_level;
	logic scl_rise;
	logic scl_fall;
	logic start_seen;
	logic stop_seen;

	// deserializer to store
	logic word_load;
	logic [WORD_ADDR_WIDTH-1:0] word_addr;
	logic byte_write;
	logic [BYTE_WIDTH-1:0] byte_data;

	i2c_line_sync sync0 (
		.Clock(Clock),
		.Reset(Reset),
		.scl(scl),
		.sda_in(sda_in),
		.scl_level(),
		.sda_level(sda_level),
		.scl_rise(scl_rise),
		.scl_fall(scl_fall),
		.start_seen(start_seen),
		.stop_seen(stop_seen)
	);

	i2c_deserializer deser0 (
		.Clock(Clock),
		.Reset(Reset),
		.sda_level(sda_level),
		.scl_rise(scl_rise),
		.scl_fall(scl_fall),
		.start_seen(start_seen),
		.stop_seen(stop_seen),
		.dev_select(dev_select),
		.sda_drive_low(sda_drive_low),
		.bus_busy(bus_busy),
		.word_load(word_load),
		.word_addr(word_addr),
		.byte_write(byte_write),
		.byte_data(byte_data)
	);

	burst_store store0 (
		.Clock(Clock),
		.Reset(Reset),
		.word_load(word_load),
		.word_addr(word_addr),
		.byte_write(byte_write),
		.byte_data(byte_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.write_strobe(write_strobe),
		.write_addr(write_addr),
		.write_data(write_data)
	);

endmodule

/* src/burst_store.sv */
`timescale 1ns/1ps

module burst_store (
	input  logic Clock,
	input  logic Reset,
	input  logic word_load,
	input  logic [i2c_pkg::WORD_ADDR_WIDTH-1:0] word_addr,
	input  logic byte_write,
	input  logic [i2c_pkg::BYTE_WIDTH-1:0] byte_data,
	input  logic [i2c_pkg::WORD_ADDR_WIDTH-1:0] rd_addr,
	output logic [i2c_pkg::BYTE_WIDTH-1:0] rd_data,
	output logic write_strobe,
	output logic [i2c_pkg::WORD_ADDR_WIDTH-1:0] write_addr,
	output logic [i2c_pkg::BYTE_WIDTH-1:0] write_data
);

	import i2c_pkg::*;

	logic [BYTE_WIDTH-1:0] mem [MEM_DEPTH];
	logic [WORD_ADDR_WIDTH-1:0] wr_ptr;

	////////////////////////////////////////////////////////////////////////////
	// write pointer
	////////////////////////////////////////////////////////////////////////////

	// bump the cycle after the write, wrapping at the top of the store
	always_ff @(posedge Clock or negedge Reset)
	begin
		if (!Reset)
		begin
			wr_ptr <= '0;
			write_strobe <= 1'b0;
		end
		else
		begin
			write_strobe <= byte_write;
			if (word_load)
			begin
				wr_ptr <= word_addr;
			end
			else if (write_strobe)
			begin
				if (wr_ptr == WORD_ADDR_WIDTH'(MEM_DEPTH - 1))
				begin
					wr_ptr <= '0;
				end
				else
				begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// byte memory
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock)
	begin
		if (byte_write)
		begin
			mem[wr_ptr] <= byte_data;
			write_addr <= wr_ptr;
			write_data <= byte_data;
		end
		// host read port, one cycle latency
		rd_data <= mem[rd_addr];
	end

endmodule

/* src/i2c_deserializer.sv */
`timescale 1ns/1ps

module i2c_deserializer (
	input  logic Clock,
	input  logic Reset,
	input  logic sda_level,
	input  logic scl_rise,
	input  logic scl_fall,
	input  logic start_seen,
	input  logic stop_seen,
	input  logic [i2c_pkg::DEV_SEL_WIDTH-1:0] dev_select,
	output logic sda_drive_low,
	output logic bus_busy,
	output logic word_load,
	output logic [i2c_pkg::WORD_ADDR_WIDTH-1:0] word_addr,
	output logic byte_write,
	output logic [i2c_pkg::BYTE_WIDTH-1:0] byte_data
);

	import i2c_pkg::*;

	bus_phase_t phase;
	logic [BIT_CNT_WIDTH-1:0] bit_cnt;
	logic [BYTE_WIDTH-1:0] shift_reg;
	logic [WORD_HI_WIDTH-1:0] word_hi;

	logic active;
	logic shifting;
	logic byte_done;
	logic ack_done;
	logic addr_match;

	////////////////////////////////////////////////////////////////////////////
	// byte framing
	////////////////////////////////////////////////////////////////////////////

	// idle and ignore never touch the bus
	assign active = (phase != phase_idle) && (phase != phase_ignore);
	assign shifting = active && (bit_cnt < BIT_CNT_FULL);

	// falling edge after the 8th bit opens the acknowledge slot
	assign byte_done = active && scl_fall && (bit_cnt == BIT_CNT_FULL);
	assign ack_done = active && scl_fall && (bit_cnt == BIT_CNT_ACK);

	// 1010 + straps, write direction only
	assign addr_match = (shift_reg[BYTE_WIDTH-1:1] == {DEV_ID_PREFIX, dev_select})
		&& !shift_reg[0];

	////////////////////////////////////////////////////////////////////////////
	// phase machine
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset)
	begin
		if (!Reset)
		begin
			phase <= phase_idle;
			bit_cnt <= '0;
			sda_drive_low <= 1'b0;
			bus_busy <= 1'b0;
			word_load <= 1'b0;
			byte_write <= 1'b0;
		end
		else
		begin
			word_load <= 1'b0;
			byte_write <= 1'b0;

			if (stop_seen)
			begin
				// partial byte is simply dropped
				phase <= phase_idle;
				bit_cnt <= '0;
				sda_drive_low <= 1'b0;
				bus_busy <= 1'b0;
			end
			else if (start_seen)
			begin
				// also covers repeated start
				phase <= phase_dev_addr;
				bit_cnt <= '0;
				sda_drive_low <= 1'b0;
				bus_busy <= 1'b1;
			end
			else if (shifting && scl_rise)
			begin
				bit_cnt <= bit_cnt + 1'b1;
			end
			else if (byte_done)
			begin
				bit_cnt <= BIT_CNT_ACK;
				sda_drive_low <= 1'b1;
				case (phase)
					phase_dev_addr:
					begin
						if (addr_match)
						begin
							phase <= phase_word_hi;
						end
						else
						begin
							// wrong device or a read, stay off the bus
							phase <= phase_ignore;
							bit_cnt <= '0;
							sda_drive_low <= 1'b0;
						end
					end
					phase_word_hi:
					begin
						phase <= phase_word_lo;
					end
					phase_word_lo:
					begin
						phase <= phase_data;
						word_load <= 1'b1;
					end
					phase_data:
					begin
						byte_write <= 1'b1;
					end
					default:
					begin
						phase <= phase_ignore;
						sda_drive_low <= 1'b0;
					end
				endcase
			end
			else if (ack_done)
			begin
				// release sda after the 9th clock
				sda_drive_low <= 1'b0;
				bit_cnt <= '0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// data path
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock)
	begin
		// msb first
		if (shifting && scl_rise)
		begin
			shift_reg <= {shift_reg[BYTE_WIDTH-2:0], sda_level};
		end
		if (byte_done && (phase == phase_word_hi))
		begin
			word_hi <= shift_reg[WORD_HI_WIDTH-1:0];
		end
		if (byte_done && (phase == phase_word_lo))
		begin
			word_addr <= {word_hi, shift_reg};
		end
		if (byte_done && (phase == phase_data))
		begin
			byte_data <= shift_reg;
		end
	end

endmodule

/* src/i2c_line_sync.sv */
`timescale 1ns/1ps

module i2c_line_sync (
	input  logic Clock,
	input  logic Reset,
	input  logic scl,
	input  logic sda_in,
	output logic scl_level,
	output logic sda_level,
	output logic scl_rise,
	output logic scl_fall,
	output logic start_seen,
	output logic stop_seen
);

	// two synchronizer stages per line
	logic scl_s1;
	logic scl_s2;
	logic sda_s1;
	logic sda_s2;

	// previous synchronized values, also the exported levels
	logic scl_prev;
	logic sda_prev;

	assign scl_level = scl_prev;
	assign sda_level = sda_prev;

	////////////////////////////////////////////////////////////////////////////
	// synchronizer
	////////////////////////////////////////////////////////////////////////////

	// idle bus is high on both lines
	always_ff @(posedge Clock or negedge Reset)
	begin
		if (!Reset)
		begin
			scl_s1 <= 1'b1;
			scl_s2 <= 1'b1;
			sda_s1 <= 1'b1;
			sda_s2 <= 1'b1;
			scl_prev <= 1'b1;
			sda_prev <= 1'b1;
		end
		else
		begin
			scl_s1 <= scl;
			scl_s2 <= scl_s1;
			sda_s1 <= sda_in;
			sda_s2 <= sda_s1;
			scl_prev <= scl_s2;
			sda_prev <= sda_s2;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// edge and bus condition pulses
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset)
	begin
		if (!Reset)
		begin
			scl_rise <= 1'b0;
			scl_fall <= 1'b0;
			start_seen <= 1'b0;
			stop_seen <= 1'b0;
		end
		else
		begin
			scl_rise <= scl_s2 && !scl_prev;
			scl_fall <= !scl_s2 && scl_prev;
			// sda moving while scl stays high
			start_seen <= !sda_s2 && sda_prev && scl_s2 && scl_prev;
			stop_seen <= sda_s2 && !sda_prev && scl_s2 && scl_prev;
		end
	end

endmodule

/* src/i2c_pkg.sv */
package i2c_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bus and store dimensions
	////////////////////////////////////////////////////////////////////////////

	localparam int BYTE_WIDTH = 8;
	localparam int WORD_ADDR_WIDTH = 11;
	localparam int MEM_DEPTH = 2048;

	// upper word-address byte only contributes its low bits
	localparam int WORD_HI_WIDTH = WORD_ADDR_WIDTH - BYTE_WIDTH;

	// strap pins complete the 7-bit device address
	localparam int DEV_SEL_WIDTH = 3;
	localparam logic [3:0] DEV_ID_PREFIX = 4'b1010;

	////////////////////////////////////////////////////////////////////////////
	// bit counter
	////////////////////////////////////////////////////////////////////////////

	localparam int BIT_CNT_WIDTH = 4;

	// 8 data bits shifted in, then the acknowledge slot
	localparam logic [BIT_CNT_WIDTH-1:0] BIT_CNT_FULL = BIT_CNT_WIDTH'(BYTE_WIDTH);
	localparam logic [BIT_CNT_WIDTH-1:0] BIT_CNT_ACK = BIT_CNT_WIDTH'(BYTE_WIDTH + 1);

	////////////////////////////////////////////////////////////////////////////
	// deserializer phases
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		phase_idle,
		phase_dev_addr,
		phase_word_hi,
		phase_word_lo,
		phase_data,
		phase_ignore
	} bus_phase_t;

endpackage
